// ==== spim_ctrl.f ====
spim_pkg.sv
spim_wait_counter.sv
spim_cfg_regs.sv
spim_sequencer.sv
spim_ctrl.sv
spim_ctrl_sva.sv
tb_spim_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the spim_ctrl testbench with Verilator.
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_spim_ctrl \
	-f spim_ctrl.f -Mdir obj_dir -o tb_sim

./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== tb_spim_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_spim_ctrl import spim_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic              clk_i;
	logic              rstn_i;
	logic [CMD_W-1:0]  udma_cmd_i;
	logic              udma_cmd_valid_i;
	logic              udma_cmd_ready_o;
	logic [DATA_W-1:0] udma_tx_data_i;
	logic              udma_tx_data_valid_i;
	logic              udma_tx_data_ready_o;
	logic [DATA_W-1:0] udma_rx_data_o;
	logic              udma_rx_data_valid_o;
	logic              udma_rx_data_ready_i;
	logic              tx_start_o;
	spim_xfer_t        tx_xfer_o;
	logic              tx_done_i;
	logic [DATA_W-1:0] tx_data_o;
	logic              tx_data_valid_o;
	logic              tx_data_ready_i;
	logic              rx_start_o;
	spim_xfer_t        rx_xfer_o;
	logic              rx_done_i;
	logic [DATA_W-1:0] rx_data_i;
	logic              rx_data_valid_i;
	logic              rx_data_ready_o;
	spim_clk_cfg_t     clk_cfg_o;
	logic              clk_cfg_update_o;
	logic [3:0]        spi_csn_o;
	logic [3:0]        event_i;
	logic              eot_o;

	int          n_mismatch;
	int          n_other;
	logic [31:0] exp_tx_q[$];
	logic [31:0] exp_rx_q[$];
	logic        busy; // High while a transfer waits for its done pulse.
	logic        prev_tx_start;
	logic        prev_rx_start;
	logic        acc_tx_start;
	logic        acc_rx_start;
	logic        acc_tx_valid;
	logic        acc_eot;
	logic [31:0] acc_tx_data;
	spim_xfer_t  acc_tx_xfer;
	spim_xfer_t  acc_rx_xfer;
	logic [3:0]  exp_csn;
	logic        exp_qpi; // Quad flag held since the last start.

	spim_ctrl DUT (
		.clk_i                (clk_i),
		.rstn_i               (rstn_i),
		.udma_cmd_i           (udma_cmd_i),
		.udma_cmd_valid_i     (udma_cmd_valid_i),
		.udma_cmd_ready_o     (udma_cmd_ready_o),
		.udma_tx_data_i       (udma_tx_data_i),
		.udma_tx_data_valid_i (udma_tx_data_valid_i),
		.udma_tx_data_ready_o (udma_tx_data_ready_o),
		.udma_rx_data_o       (udma_rx_data_o),
		.udma_rx_data_valid_o (udma_rx_data_valid_o),
		.udma_rx_data_ready_i (udma_rx_data_ready_i),
		.tx_start_o           (tx_start_o),
		.tx_xfer_o            (tx_xfer_o),
		.tx_done_i            (tx_done_i),
		.tx_data_o            (tx_data_o),
		.tx_data_valid_o      (tx_data_valid_o),
		.tx_data_ready_i      (tx_data_ready_i),
		.rx_start_o           (rx_start_o),
		.rx_xfer_o            (rx_xfer_o),
		.rx_done_i            (rx_done_i),
		.rx_data_i            (rx_data_i),
		.rx_data_valid_i      (rx_data_valid_i),
		.rx_data_ready_o      (rx_data_ready_o),
		.clk_cfg_o            (clk_cfg_o),
		.clk_cfg_update_o     (clk_cfg_update_o),
		.spi_csn_o            (spi_csn_o),
		.event_i              (event_i),
		.eot_o                (eot_o)
	);

	always #2 clk_i = ~clk_i;

	function automatic spim_xfer_t ref_xfer(input logic [31:0] cmd);
		spim_xfer_t x;
		x           = '0;
		x.qpi       = cmd[27];
		x.bits_word = cmd[20:16];
		if (cmd[31:28] != 4'd2) begin // SEND_CMD keeps size and word count at zero.
			x.size      = cmd[15:0];
			x.lsb_first = cmd[26];
			if (cmd[22:21] == 2'd1)
				x.word_transf = 2'd1;
			else if (cmd[22:21] == 2'd2)
				x.word_transf = 2'd3;
		end
		return x;
	endfunction

	function automatic spim_clk_cfg_t ref_clk(input logic [31:0] cmd);
		spim_clk_cfg_t c;
		c.cpol   = cmd[9];
		c.cpha   = cmd[8];
		c.clkdiv = cmd[7:0];
		return c;
	endfunction

	function automatic logic [3:0] ref_csn(input logic [3:0] cur, input logic [31:0] cmd);
		logic [3:0] n;
		n = cur;
		if (cmd[31:28] == 4'd1)
			n[cmd[1:0]] = 1'b0;
		else if (cmd[31:28] == 4'd9 && !cmd[1])
			n = 4'hf;
		return n;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		n_mismatch++;
		$display("mismatch at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
	endtask

	task automatic report_error(input string msg);
		n_other++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// Called 1 ns after a rising edge and returns 1 ns after the accept edge.
	task automatic issue_cmd(input logic [31:0] cmd);
		int t;
		t                = 0;
		udma_cmd_i       = cmd;
		udma_cmd_valid_i = 1'b1;
		#2;
		while (!udma_cmd_ready_o && t < TIMEOUT) begin
			@(posedge clk_i);
			#3;
			t++;
		end
		if (!udma_cmd_ready_o)
			report_error("command not accepted before timeout");
		acc_tx_start = tx_start_o; // Outputs of the accept cycle.
		acc_rx_start = rx_start_o;
		acc_tx_valid = tx_data_valid_o;
		acc_tx_data  = tx_data_o;
		acc_tx_xfer  = tx_xfer_o;
		acc_rx_xfer  = rx_xfer_o;
		acc_eot      = eot_o;
		@(posedge clk_i);
		#1;
		udma_cmd_valid_i = 1'b0;
	endtask

	task automatic wait_idle(output int n);
		n = 0;
		#2;
		while (!udma_cmd_ready_o && n < TIMEOUT) begin
			@(posedge clk_i);
			#3;
			n++;
		end
		if (!udma_cmd_ready_o)
			report_error("sequencer did not return to idle before timeout");
		@(posedge clk_i);
		#1;
	endtask

	task automatic move_tx_beats(input int nbeats);
		fork
			begin
				int          t;
				logic        hs;
				logic [31:0] d;
				for (int i = 0; i < nbeats; i++) begin
					repeat ($urandom % 3) begin
						@(posedge clk_i);
						#1;
					end
					d = $urandom;
					exp_tx_q.push_back(d);
					udma_tx_data_i       = d;
					udma_tx_data_valid_i = 1'b1;
					t = 0;
					do begin
						@(negedge clk_i);
						hs = udma_tx_data_valid_i && udma_tx_data_ready_o;
						@(posedge clk_i);
						#1;
						t++;
					end while (!hs && t < TIMEOUT);
					if (!hs)
						report_error("tx beat not taken before timeout");
					udma_tx_data_valid_i = 1'b0;
				end
			end
			begin
				int got;
				int t;
				got = 0;
				t   = 0;
				while (got < nbeats && t < TIMEOUT) begin
					tx_data_ready_i = 1'($urandom); // Random shifter stalls.
					@(negedge clk_i);
					if (tx_data_valid_o && tx_data_ready_i)
						got++;
					@(posedge clk_i);
					#1;
					t++;
				end
				tx_data_ready_i = 1'b0;
				if (got < nbeats)
					report_error("transmit shifter model got too few beats");
			end
		join
	endtask

	task automatic move_rx_beats(input int nbeats);
		fork
			begin
				int          t;
				logic        hs;
				logic [31:0] d;
				for (int i = 0; i < nbeats; i++) begin
					repeat ($urandom % 3) begin
						@(posedge clk_i);
						#1;
					end
					d = $urandom;
					exp_rx_q.push_back(d);
					rx_data_i       = d;
					rx_data_valid_i = 1'b1;
					t = 0;
					do begin
						@(negedge clk_i);
						hs = rx_data_valid_i && rx_data_ready_o;
						@(posedge clk_i);
						#1;
						t++;
					end while (!hs && t < TIMEOUT);
					if (!hs)
						report_error("rx beat not taken before timeout");
					rx_data_valid_i = 1'b0;
				end
			end
			begin
				int got;
				int t;
				got = 0;
				t   = 0;
				while (got < nbeats && t < TIMEOUT) begin
					udma_rx_data_ready_i = 1'($urandom);
					@(negedge clk_i);
					if (udma_rx_data_valid_o && udma_rx_data_ready_i)
						got++;
					@(posedge clk_i);
					#1;
					t++;
				end
				udma_rx_data_ready_i = 1'b0;
				if (got < nbeats)
					report_error("uDMA receive side got too few beats");
			end
		join
	endtask

	task automatic end_xfer(input logic rx);
		int n;
		if (rx)
			rx_done_i = 1'b1;
		else
			tx_done_i = 1'b1;
		busy = 1'b0;
		@(posedge clk_i);
		#1;
		rx_done_i = 1'b0;
		tx_done_i = 1'b0;
		wait_idle(n);
	endtask

	always @(negedge clk_i) begin
		if (rstn_i) begin
			if (tx_data_valid_o && tx_data_ready_i && !tx_start_o) begin
				if (exp_tx_q.size() == 0) begin
					report_error("unexpected beat on tx_data_o");
				end else begin
					if (tx_data_o !== exp_tx_q[0])
						report_mismatch("tx_data_o", exp_tx_q[0], tx_data_o);
					void'(exp_tx_q.pop_front());
				end
			end
			if (udma_rx_data_valid_o && udma_rx_data_ready_i) begin
				if (exp_rx_q.size() == 0) begin
					report_error("unexpected beat on udma_rx_data_o");
				end else begin
					if (udma_rx_data_o !== exp_rx_q[0])
						report_mismatch("udma_rx_data_o", exp_rx_q[0], udma_rx_data_o);
					void'(exp_rx_q.pop_front());
				end
			end
			if (busy && udma_cmd_ready_o)
				report_error("command ready before the done pulse");
			if ((tx_start_o && prev_tx_start) || (rx_start_o && prev_rx_start))
				report_error("start strobe longer than one cycle");
			prev_tx_start = tx_start_o;
			prev_rx_start = rx_start_o;
		end
	end

	initial begin
		logic [31:0] cmd;
		logic [1:0]  cs;
		logic [1:0]  sel;
		logic        keep;
		logic        evt;
		int          n;
		int          upd;
		int          ncyc;
		void'($urandom(13286));
		clk_i = 1'b0;
		rstn_i = 1'b0;
		udma_cmd_i = '0;
		udma_cmd_valid_i = 1'b0;
		udma_tx_data_i = '0;
		udma_tx_data_valid_i = 1'b0;
		udma_rx_data_ready_i = 1'b0;
		tx_done_i = 1'b0;
		tx_data_ready_i = 1'b0;
		rx_done_i = 1'b0;
		rx_data_i = '0;
		rx_data_valid_i = 1'b0;
		event_i = '0;
		n_mismatch = 0;
		n_other = 0;
		busy = 1'b0;
		prev_tx_start = 1'b0;
		prev_rx_start = 1'b0;
		exp_csn = 4'hf;
		exp_qpi = 1'b0;
		repeat (8) @(posedge clk_i);
		#1;
		rstn_i = 1'b1;
		@(posedge clk_i);
		#1;
		if (udma_cmd_ready_o !== 1'b1 || spi_csn_o !== 4'hf || clk_cfg_o !== '0)
			report_error("outputs not at their reset values");
		if ({tx_start_o, rx_start_o, tx_data_valid_o, udma_rx_data_valid_o, eot_o,
				clk_cfg_update_o} !== 6'd0)
			report_error("a strobe or valid is active after reset");

		repeat (2) begin
			cmd = {4'd0, 18'd0, 10'($urandom)};
			issue_cmd(cmd);
			upd = 0;
			for (int k = 0; k < 4; k++) begin
				@(negedge clk_i);
				if (k == 0 && clk_cfg_o !== ref_clk(cmd))
					report_mismatch("clk_cfg_o", 32'(ref_clk(cmd)), 32'(clk_cfg_o));
				if (clk_cfg_update_o)
					upd++;
			end
			if (upd != 1)
				report_error("clk_cfg_update_o did not pulse exactly once");
			@(posedge clk_i);
			#1;
			wait_idle(n);
		end

		// First pass keeps the chip select and the second releases all.
		for (int pass = 0; pass < 2; pass++) begin
			cs  = 2'($urandom);
			cmd = {4'd1, 12'd0, 8'($urandom % 6), 6'd0, cs};
			issue_cmd(cmd);
			exp_csn = ref_csn(exp_csn, cmd);
			#2;
			if (spi_csn_o !== exp_csn)
				report_mismatch("spi_csn_o", 32'(exp_csn), 32'(spi_csn_o));
			@(posedge clk_i);
			#1;
			wait_idle(n);
			keep = (pass == 0);
			evt  = 1'($urandom);
			cmd  = {4'd9, 26'd0, keep, evt};
			issue_cmd(cmd);
			if (acc_eot !== evt)
				report_mismatch("eot_o", 32'(evt), 32'(acc_eot));
			exp_csn = ref_csn(exp_csn, cmd);
			wait_idle(n);
			if (spi_csn_o !== exp_csn)
				report_mismatch("spi_csn_o", 32'(exp_csn), 32'(spi_csn_o));
		end

		for (int i = 0; i < 4; i++) begin
			cmd = {4'd6, 1'($urandom), 1'($urandom), 3'd0, 2'(i), 5'($urandom), 16'($urandom)};
			issue_cmd(cmd);
			busy = 1'b1;
			if (acc_tx_start !== 1'b1)
				report_error("tx_start_o missing in the accept cycle");
			if (acc_tx_xfer !== ref_xfer(cmd))
				report_mismatch("tx_xfer_o", 32'(ref_xfer(cmd)), 32'(acc_tx_xfer));
			if (acc_rx_xfer !== {24'd0, exp_qpi})
				report_mismatch("rx_xfer_o", {31'd0, exp_qpi}, 32'(acc_rx_xfer));
			exp_qpi = cmd[27];
			move_tx_beats(1 + int'($urandom % 6));
			end_xfer(1'b0);
		end

		for (int i = 0; i < 3; i++) begin
			cmd = {4'd7, 1'($urandom), 1'($urandom), 3'd0, 2'($urandom), 5'($urandom),
				16'($urandom)};
			issue_cmd(cmd);
			busy = 1'b1;
			if (acc_rx_start !== 1'b1)
				report_error("rx_start_o missing in the accept cycle");
			if (acc_rx_xfer !== ref_xfer(cmd))
				report_mismatch("rx_xfer_o", 32'(ref_xfer(cmd)), 32'(acc_rx_xfer));
			if (acc_tx_xfer !== {24'd0, exp_qpi})
				report_mismatch("tx_xfer_o", {31'd0, exp_qpi}, 32'(acc_tx_xfer));
			exp_qpi = cmd[27];
			move_rx_beats(1 + int'($urandom % 6));
			end_xfer(1'b1);
		end

		cmd = {4'd2, 28'($urandom)};
		issue_cmd(cmd);
		busy = 1'b1;
		if (acc_tx_start !== 1'b1 || acc_tx_valid !== 1'b1)
			report_error("SEND_CMD did not strobe start and data valid");
		if (acc_tx_data !== {16'd0, cmd[15:0]})
			report_mismatch("tx_data_o", {16'd0, cmd[15:0]}, acc_tx_data);
		if (acc_tx_xfer !== ref_xfer(cmd))
			report_mismatch("tx_xfer_o", 32'(ref_xfer(cmd)), 32'(acc_tx_xfer));
		end_xfer(1'b0);

		repeat (2) begin
			sel          = 2'($urandom);
			event_i      = 4'hf; // Only the selected event stays low.
			event_i[sel] = 1'b0;
			cmd = {4'd5, 18'd0, 2'd0, 6'd0, sel};
			issue_cmd(cmd);
			for (int k = 0; k < 5; k++) begin
				@(negedge clk_i);
				if (udma_cmd_ready_o)
					report_error("event wait ended while the event was low");
			end
			@(posedge clk_i);
			#1;
			event_i[sel] = 1'b1;
			wait_idle(n);
			event_i = '0;
			ncyc = int'($urandom % 12);
			cmd  = {4'd5, 18'd0, 2'd1, 8'(ncyc)};
			issue_cmd(cmd);
			wait_idle(n);
			if (n < ncyc + 1)
				report_error("cycle wait ended too early");
		end

		if (exp_tx_q.size() != 0 || exp_rx_q.size() != 0)
			report_error("data beats left that never came out");
		$display("mismatches %0d, other errors %0d", n_mismatch, n_other);
		if (n_mismatch + n_other == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== spim_ctrl_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module spim_ctrl_sva (
	input wire clk_i,
	input wire rstn_i,
	input wire tx_start_o,
	input wire rx_start_o,
	input wire clk_cfg_update_o,
	input wire udma_rx_data_valid_o,
	input wire rx_data_valid_i
);

	// Only one shifter runs at a time.
	a_one_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
		!(tx_start_o && rx_start_o))
		else $error("tx_start_o and rx_start_o high together");

	a_cfg_update_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
		clk_cfg_update_o |=> !clk_cfg_update_o)
		else $error("clk_cfg_update_o high for more than one cycle");

	a_rx_valid_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
		udma_rx_data_valid_o |-> rx_data_valid_i)
		else $error("udma_rx_data_valid_o high without rx_data_valid_i");

endmodule

bind spim_ctrl spim_ctrl_sva u_sva (
	.clk_i                (clk_i),
	.rstn_i               (rstn_i),
	.tx_start_o           (tx_start_o),
	.rx_start_o           (rx_start_o),
	.clk_cfg_update_o     (clk_cfg_update_o),
	.udma_rx_data_valid_o (udma_rx_data_valid_o),
	.rx_data_valid_i      (rx_data_valid_i)
);

`default_nettype wire

// ==== spim_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module spim_ctrl import spim_pkg::*; (
	input  wire                clk_i,
	input  wire                rstn_i,
	input  wire [CMD_W-1:0]    udma_cmd_i,
	input  wire                udma_cmd_valid_i,
	output logic               udma_cmd_ready_o,
	input  wire [DATA_W-1:0]   udma_tx_data_i,
	input  wire                udma_tx_data_valid_i,
	output logic               udma_tx_data_ready_o,
	output logic [DATA_W-1:0]  udma_rx_data_o,
	output logic               udma_rx_data_valid_o,
	input  wire                udma_rx_data_ready_i,
	output logic               tx_start_o,
	output spim_xfer_t         tx_xfer_o,
	input  wire                tx_done_i,
	output logic [DATA_W-1:0]  tx_data_o,
	output logic               tx_data_valid_o,
	input  wire                tx_data_ready_i,
	output logic               rx_start_o,
	output spim_xfer_t         rx_xfer_o,
	input  wire                rx_done_i,
	input  wire [DATA_W-1:0]   rx_data_i,
	input  wire                rx_data_valid_i,
	output logic               rx_data_ready_o,
	output spim_clk_cfg_t      clk_cfg_o,
	output logic               clk_cfg_update_o,
	output logic [NUM_CS-1:0]  spi_csn_o,
	input  wire [NUM_EVT-1:0]  event_i,
	output logic               eot_o
);

	logic [CMD_W-1:0] cmd_word;
	logic             ld_clk_cfg;
	logic             ld_cs;
	logic             clr_cs;
	logic             ld_evt;
	logic             ld_qpi;
	logic             qpi;
	logic             evt_hit;
	logic             cnt_start;
	logic [CNT_W-1:0] cnt_target;
	logic             cnt_done;

	spim_sequencer u_sequencer (
		.clk_i                (clk_i),
		.rstn_i               (rstn_i),
		.udma_cmd_i           (udma_cmd_i),
		.udma_cmd_valid_i     (udma_cmd_valid_i),
		.udma_cmd_ready_o     (udma_cmd_ready_o),
		.udma_tx_data_i       (udma_tx_data_i),
		.udma_tx_data_valid_i (udma_tx_data_valid_i),
		.udma_tx_data_ready_o (udma_tx_data_ready_o),
		.udma_rx_data_o       (udma_rx_data_o),
		.udma_rx_data_valid_o (udma_rx_data_valid_o),
		.udma_rx_data_ready_i (udma_rx_data_ready_i),
		.tx_start_o           (tx_start_o),
		.tx_xfer_o            (tx_xfer_o),
		.tx_done_i            (tx_done_i),
		.tx_data_o            (tx_data_o),
		.tx_data_valid_o      (tx_data_valid_o),
		.tx_data_ready_i      (tx_data_ready_i),
		.rx_start_o           (rx_start_o),
		.rx_xfer_o            (rx_xfer_o),
		.rx_done_i            (rx_done_i),
		.rx_data_i            (rx_data_i),
		.rx_data_valid_i      (rx_data_valid_i),
		.rx_data_ready_o      (rx_data_ready_o),
		.eot_o                (eot_o),
		.cmd_word_o           (cmd_word),
		.ld_clk_cfg_o         (ld_clk_cfg),
		.ld_cs_o              (ld_cs),
		.clr_cs_o             (clr_cs),
		.ld_evt_o             (ld_evt),
		.ld_qpi_o             (ld_qpi),
		.qpi_i                (qpi),
		.evt_hit_i            (evt_hit),
		.cnt_start_o          (cnt_start),
		.cnt_target_o         (cnt_target),
		.cnt_done_i           (cnt_done)
	);

	spim_cfg_regs u_cfg_regs (
		.clk_i            (clk_i),
		.rstn_i           (rstn_i),
		.cmd_word_i       (cmd_word),
		.ld_clk_cfg_i     (ld_clk_cfg),
		.ld_cs_i          (ld_cs),
		.clr_cs_i         (clr_cs),
		.ld_evt_i         (ld_evt),
		.ld_qpi_i         (ld_qpi),
		.event_i          (event_i),
		.clk_cfg_o        (clk_cfg_o),
		.clk_cfg_update_o (clk_cfg_update_o),
		.spi_csn_o        (spi_csn_o),
		.qpi_o            (qpi),
		.evt_hit_o        (evt_hit)
	);

	spim_wait_counter u_wait_counter (
		.clk_i    (clk_i),
		.rstn_i   (rstn_i),
		.start_i  (cnt_start),
		.target_i (cnt_target),
		.done_o   (cnt_done)
	);

endmodule

`default_nettype wire

// ==== spim_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module spim_sequencer import spim_pkg::*; (
	input  wire                clk_i,
	input  wire                rstn_i,
	input  wire [CMD_W-1:0]    udma_cmd_i,
	input  wire                udma_cmd_valid_i,
	output logic               udma_cmd_ready_o,
	input  wire [DATA_W-1:0]   udma_tx_data_i,
	input  wire                udma_tx_data_valid_i,
	output logic               udma_tx_data_ready_o,
	output logic [DATA_W-1:0]  udma_rx_data_o,
	output logic               udma_rx_data_valid_o,
	input  wire                udma_rx_data_ready_i,
	output logic               tx_start_o,
	output spim_xfer_t         tx_xfer_o,
	input  wire                tx_done_i,
	output logic [DATA_W-1:0]  tx_data_o,
	output logic               tx_data_valid_o,
	input  wire                tx_data_ready_i,
	output logic               rx_start_o,
	output spim_xfer_t         rx_xfer_o,
	input  wire                rx_done_i,
	input  wire [DATA_W-1:0]   rx_data_i,
	input  wire                rx_data_valid_i,
	output logic               rx_data_ready_o,
	output logic               eot_o,
	output logic [CMD_W-1:0]   cmd_word_o,
	output logic               ld_clk_cfg_o,
	output logic               ld_cs_o,
	output logic               clr_cs_o,
	output logic               ld_evt_o,
	output logic               ld_qpi_o,
	input  wire                qpi_i,
	input  wire                evt_hit_i,
	output logic               cnt_start_o,
	output logic [CNT_W-1:0]   cnt_target_o,
	input  wire                cnt_done_i
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_XFER,
		ST_WAIT_EVT,
		ST_WAIT_CNT,
		ST_RELEASE
	} state_e;

	state_e     state_q;
	state_e     state_d;
	spim_op_e   op;
	spim_xfer_t xfer_cmd;
	logic [1:0] wtransf;

	assign op               = spim_op_e'(udma_cmd_i[OP_HI:OP_LO]);
	assign cmd_word_o       = udma_cmd_i;
	assign udma_cmd_ready_o = (state_q == ST_IDLE);

	always_comb begin
		case (udma_cmd_i[WTRANSF_HI:WTRANSF_LO])
			2'd1:    wtransf = 2'd1;
			2'd2:    wtransf = 2'd3;
			default: wtransf = 2'd0;
		endcase
	end

	assign xfer_cmd = '{
		size:        udma_cmd_i[SIZE_HI:SIZE_LO],
		bits_word:   udma_cmd_i[WSIZE_HI:WSIZE_LO],
		word_transf: wtransf,
		lsb_first:   udma_cmd_i[LSB_BIT],
		qpi:         udma_cmd_i[QPI_BIT]
	};

	always_comb begin
		state_d              = state_q;
		tx_start_o           = 1'b0;
		rx_start_o           = 1'b0;
		tx_xfer_o            = '0;
		tx_xfer_o.qpi        = qpi_i;
		rx_xfer_o            = '0;
		rx_xfer_o.qpi        = qpi_i;
		tx_data_o            = '0;
		tx_data_valid_o      = 1'b0;
		udma_tx_data_ready_o = 1'b0;
		udma_rx_data_o       = '0;
		udma_rx_data_valid_o = 1'b0;
		rx_data_ready_o      = 1'b0;
		ld_clk_cfg_o         = 1'b0;
		ld_cs_o              = 1'b0;
		clr_cs_o             = 1'b0;
		ld_evt_o             = 1'b0;
		ld_qpi_o             = 1'b0;
		eot_o                = 1'b0;
		cnt_start_o          = 1'b0;
		cnt_target_o         = '0;
		case (state_q)
			ST_IDLE: if (udma_cmd_valid_i) begin
				case (op)
					OP_CFG: begin
						ld_clk_cfg_o = 1'b1;
						cnt_start_o  = 1'b1;
						cnt_target_o = CNT_W'(CFG_SETTLE_CYC); // Let the new clock settle.
						state_d      = ST_WAIT_CNT;
					end
					OP_SOT: begin
						ld_cs_o      = 1'b1;
						cnt_start_o  = 1'b1;
						cnt_target_o = udma_cmd_i[CSWAIT_HI:CSWAIT_LO];
						state_d      = ST_WAIT_CNT;
					end
					OP_SEND_CMD: begin
						ld_qpi_o            = 1'b1;
						tx_start_o          = 1'b1;
						tx_xfer_o.bits_word = xfer_cmd.bits_word;
						tx_xfer_o.qpi       = xfer_cmd.qpi;
						tx_data_o           = DATA_W'(udma_cmd_i[SIZE_HI:SIZE_LO]);
						tx_data_valid_o     = 1'b1;
						state_d             = ST_XFER;
					end
					OP_TX_DATA: begin
						ld_qpi_o   = 1'b1;
						tx_start_o = 1'b1;
						tx_xfer_o  = xfer_cmd;
						state_d    = ST_XFER;
					end
					OP_RX_DATA: begin
						ld_qpi_o   = 1'b1;
						rx_start_o = 1'b1;
						rx_xfer_o  = xfer_cmd;
						state_d    = ST_XFER;
					end
					OP_WAIT: begin
						if (udma_cmd_i[WTYP_HI:WTYP_LO] == 2'd0) begin
							ld_evt_o = 1'b1;
							state_d  = ST_WAIT_EVT;
						end else if (udma_cmd_i[WTYP_HI:WTYP_LO] == 2'd1) begin
							cnt_start_o  = 1'b1;
							cnt_target_o = udma_cmd_i[WCYC_HI:WCYC_LO];
							state_d      = ST_WAIT_CNT;
						end
					end
					OP_EOT: begin
						eot_o = udma_cmd_i[EOT_EVT_BIT];
						if (!udma_cmd_i[EOT_KEEP_BIT])
							state_d = ST_RELEASE;
					end
					default: state_d = ST_IDLE; // Unknown opcodes are dropped.
				endcase
			end
			ST_XFER: begin
				tx_data_o            = udma_tx_data_i;
				tx_data_valid_o      = udma_tx_data_valid_i;
				udma_tx_data_ready_o = tx_data_ready_i;
				udma_rx_data_o       = rx_data_i;
				udma_rx_data_valid_o = rx_data_valid_i;
				rx_data_ready_o      = udma_rx_data_ready_i;
				if (tx_done_i || rx_done_i)
					state_d = ST_IDLE; // Only one shifter runs at a time.
			end
			ST_WAIT_EVT: if (evt_hit_i) state_d = ST_IDLE;
			ST_WAIT_CNT: if (cnt_done_i) state_d = ST_IDLE;
			ST_RELEASE: begin
				clr_cs_o = 1'b1;
				state_d  = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

endmodule

`default_nettype wire

// ==== spim_cfg_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module spim_cfg_regs import spim_pkg::*; (
	input  wire                 clk_i,
	input  wire                 rstn_i,
	input  wire [CMD_W-1:0]     cmd_word_i,
	input  wire                 ld_clk_cfg_i,
	input  wire                 ld_cs_i,
	input  wire                 clr_cs_i,
	input  wire                 ld_evt_i,
	input  wire                 ld_qpi_i,
	input  wire [NUM_EVT-1:0]   event_i,
	output spim_clk_cfg_t       clk_cfg_o,
	output logic                clk_cfg_update_o,
	output logic [NUM_CS-1:0]   spi_csn_o,
	output logic                qpi_o,
	output logic                evt_hit_o
);

	logic [WEVT_HI-WEVT_LO:0] evt_sel_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			clk_cfg_o        <= '0;
			clk_cfg_update_o <= 1'b0;
		end else begin
			clk_cfg_update_o <= ld_clk_cfg_i; // Pulse trails the register load by one cycle.
			if (ld_clk_cfg_i) begin
				clk_cfg_o.cpol   <= cmd_word_i[CPOL_BIT];
				clk_cfg_o.cpha   <= cmd_word_i[CPHA_BIT];
				clk_cfg_o.clkdiv <= cmd_word_i[CLKDIV_HI:CLKDIV_LO];
			end
		end
	end

	// Chip selects only drop on load, release brings all of them back up.
	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			spi_csn_o <= '1;
		end else if (ld_cs_i) begin
			spi_csn_o[cmd_word_i[CS_HI:CS_LO]] <= 1'b0;
		end else if (clr_cs_i) begin
			spi_csn_o <= '1;
		end
	end

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			qpi_o     <= 1'b0;
			evt_sel_q <= '0;
		end else begin
			if (ld_qpi_i)
				qpi_o <= cmd_word_i[QPI_BIT];
			if (ld_evt_i)
				evt_sel_q <= cmd_word_i[WEVT_HI:WEVT_LO];
		end
	end

	assign evt_hit_o = event_i[evt_sel_q]; // Level of the selected event.

endmodule

`default_nettype wire

// ==== spim_wait_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module spim_wait_counter import spim_pkg::*; (
	input  wire             clk_i,
	input  wire             rstn_i,
	input  wire             start_i,
	input  wire [CNT_W-1:0] target_i,
	output logic            done_o
);

	logic             busy_q;
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] target_q;

	assign done_o = busy_q && (cnt_q == target_q);

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (start_i) begin
			busy_q <= 1'b1;
			cnt_q  <= '0;
		end else if (done_o) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (busy_q) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_i)
			target_q <= target_i; // Held for the whole count.
	end

endmodule

`default_nettype wire

// ==== spim_pkg.sv ====
`default_nettype none

package spim_pkg;

	localparam int CMD_W          = 32;
	localparam int DATA_W         = 32;
	localparam int SIZE_W         = 16;
	localparam int BITS_W         = 5;
	localparam int NUM_CS         = 4;
	localparam int NUM_EVT        = 4;
	localparam int CNT_W          = 8;
	localparam int CFG_SETTLE_CYC = 1;

	localparam int OP_HI       = 31;
	localparam int OP_LO       = 28;
	localparam int QPI_BIT     = 27;
	localparam int LSB_BIT     = 26;
	localparam int WTRANSF_HI  = 22;
	localparam int WTRANSF_LO  = 21;
	localparam int WSIZE_HI    = 20;
	localparam int WSIZE_LO    = 16;
	localparam int SIZE_HI     = 15; // Also the SEND_CMD data field.
	localparam int SIZE_LO     = 0;
	localparam int CSWAIT_HI   = 15;
	localparam int CSWAIT_LO   = 8;
	localparam int CS_HI       = 1;
	localparam int CS_LO       = 0;
	localparam int WTYP_HI     = 9;
	localparam int WTYP_LO     = 8;
	localparam int WCYC_HI     = 7;
	localparam int WCYC_LO     = 0;
	localparam int WEVT_HI     = 1;
	localparam int WEVT_LO     = 0;
	localparam int EOT_EVT_BIT = 0;
	localparam int EOT_KEEP_BIT = 1;
	localparam int CPOL_BIT    = 9;
	localparam int CPHA_BIT    = 8;
	localparam int CLKDIV_HI   = 7;
	localparam int CLKDIV_LO   = 0;

	typedef enum logic [3:0] {
		OP_CFG      = 4'd0,
		OP_SOT      = 4'd1,
		OP_SEND_CMD = 4'd2,
		OP_WAIT     = 4'd5,
		OP_TX_DATA  = 4'd6,
		OP_RX_DATA  = 4'd7,
		OP_EOT      = 4'd9
	} spim_op_e;

	typedef struct packed {
		logic                       cpol;
		logic                       cpha;
		logic [CLKDIV_HI:CLKDIV_LO] clkdiv;
	} spim_clk_cfg_t;

	typedef struct packed {
		logic [SIZE_W-1:0] size;
		logic [BITS_W-1:0] bits_word;
		logic [1:0]        word_transf;
		logic              lsb_first;
		logic              qpi;
	} spim_xfer_t;

endpackage

`default_nettype wire
